// ==== logic/compress_pkg.sv ====
`default_nettype none

package compress_pkg;

    // Datapath sizes
    localparam int COEFF_PER_CLK  = 4;
    localparam int COEFF_W        = 12;
    localparam int LANE_BITS      = COEFF_PER_CLK * COEFF_W;
    localparam int MLKEM_Q        = 3329;
    localparam int MEM_ADDR_W     = 10;
    localparam int API_DATA_W     = 32;
    localparam int READS_PER_POLY = 64;
    localparam int READ_CNT_W     = $clog2(READS_PER_POLY);

    // The sample buffer stores and counts 4-bit granules
    localparam int CHUNK_W      = 4;
    localparam int WORD_NIBBLES = API_DATA_W / CHUNK_W;
    localparam int BUF_NIBBLES  = 32;
    localparam int BUF_W        = BUF_NIBBLES * CHUNK_W;
    localparam int BUF_CNT_W    = $clog2(BUF_NIBBLES + 1);
    localparam int AF_NIBBLES   = 16;

    // The reciprocal of 2q stays exact for every dividend below 2^24
    localparam int RECIP_SHIFT = 37;
    localparam longint unsigned RECIP_MULT =
        ((64'd1 << RECIP_SHIFT) + 2 * MLKEM_Q - 1) / (2 * MLKEM_Q);

    typedef enum logic [1:0] {
        COMPRESS_D1,
        COMPRESS_D5,
        COMPRESS_D11,
        COMPRESS_D12
    } compress_mode_e;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        STALL,
        FLUSH
    } rd_ctrl_state_e;

    typedef struct packed {
        logic                  start;
        compress_mode_e        mode;
        logic                  compare;
        logic [2:0]            num_poly;
        logic [MEM_ADDR_W-1:0] src_base;
        logic [MEM_ADDR_W-1:0] dest_base;
    } compress_cmd_t;

    typedef struct packed {
        logic                  rd_en;
        logic [MEM_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic                  wr_en;
        logic                  rd_en;
        logic [MEM_ADDR_W-1:0] addr;
        logic [API_DATA_W-1:0] wr_data;
    } api_req_t;

endpackage

`default_nettype wire

// ==== logic/compress_read_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_read_ctrl (
    input  wire                         clk,
    input  wire                         reset_n,
    input  wire                         zeroize_i,
    input  wire compress_pkg::compress_cmd_t cmd_i,
    input  wire                         almost_full_i,
    output compress_pkg::mem_rd_req_t   mem_rd_req_o,
    output logic                        reads_done_o
);

    compress_pkg::rd_ctrl_state_e state_q;
    logic [compress_pkg::READ_CNT_W-1:0] read_cnt_q;
    logic [2:0] poly_cnt_q;
    logic [2:0] num_poly_q;
    logic [compress_pkg::MEM_ADDR_W-1:0] addr_q;
    logic issue;
    logic last_in_poly;
    logic last_poly;

    // A read goes out only in READ and only while the buffer has room for it
    assign issue = (state_q == compress_pkg::READ) && !almost_full_i;
    assign last_in_poly = (32'(read_cnt_q) == compress_pkg::READS_PER_POLY - 1);
    assign last_poly = (poly_cnt_q == num_poly_q - 3'd1);

    assign mem_rd_req_o.rd_en = issue;
    assign mem_rd_req_o.addr = addr_q;
    assign reads_done_o = (state_q == compress_pkg::FLUSH);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= compress_pkg::IDLE;
            read_cnt_q <= '0;
            poly_cnt_q <= '0;
            num_poly_q <= '0;
            addr_q <= '0;
        end else if (zeroize_i) begin
            state_q <= compress_pkg::IDLE;
            read_cnt_q <= '0;
            poly_cnt_q <= '0;
            num_poly_q <= '0;
            addr_q <= '0;
        end else if (cmd_i.start) begin
            state_q <= compress_pkg::READ;
            read_cnt_q <= '0;
            poly_cnt_q <= '0;
            num_poly_q <= cmd_i.num_poly;
            addr_q <= cmd_i.src_base;
        end else begin
            case (state_q)
                compress_pkg::READ: begin
                    if (!issue) begin
                        state_q <= compress_pkg::STALL;
                    end else begin
                        addr_q <= addr_q + compress_pkg::MEM_ADDR_W'(1);
                        read_cnt_q <= read_cnt_q + compress_pkg::READ_CNT_W'(1);
                        if (last_in_poly) begin
                            read_cnt_q <= '0;
                            poly_cnt_q <= poly_cnt_q + 3'd1;
                            // FLUSH holds until the next start so done can see it
                            if (last_poly) begin
                                state_q <= compress_pkg::FLUSH;
                            end
                        end
                    end
                end
                compress_pkg::STALL: begin
                    if (!almost_full_i) begin
                        state_q <= compress_pkg::READ;
                    end
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    // FLUSH is only reached once every polynomial of the command has been read
    assert property (@(posedge clk) disable iff (!reset_n)
        (state_q == compress_pkg::FLUSH) |-> (poly_cnt_q == num_poly_q) && (read_cnt_q == '0));

endmodule

`default_nettype wire

// ==== logic/compress_coeff.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_coeff (
    input  wire [compress_pkg::COEFF_W-1:0]    coeff_i,
    input  wire compress_pkg::compress_mode_e  mode_i,
    output logic [compress_pkg::COEFF_W-1:0]   coeff_o
);

    logic [3:0] d_bits;
    logic [2*compress_pkg::COEFF_W-1:0] numer;
    logic [63:0] product;
    logic [compress_pkg::COEFF_W-1:0] quot;
    logic [compress_pkg::COEFF_W-1:0] mask;

    always_comb begin
        d_bits = 4'd12;
        case (mode_i)
            compress_pkg::COMPRESS_D1:  d_bits = 4'd1;
            compress_pkg::COMPRESS_D5:  d_bits = 4'd5;
            compress_pkg::COMPRESS_D11: d_bits = 4'd11;
            default:                    d_bits = 4'd12;
        endcase
    end

    // round(2^d x / q) is floor((2^(d+1) x + q) / 2q)
    assign numer = ((2*compress_pkg::COEFF_W)'(coeff_i) << (d_bits + 4'd1))
                 + (2*compress_pkg::COEFF_W)'(compress_pkg::MLKEM_Q);

    // Divide by 2q with a multiply and a shift
    assign product = 64'(numer) * compress_pkg::RECIP_MULT;
    assign quot = product[compress_pkg::RECIP_SHIFT +: compress_pkg::COEFF_W];

    // The mask makes the mod 2^d wrap, so 2^d itself becomes 0
    assign mask = ~({compress_pkg::COEFF_W{1'b1}} << d_bits);

    assign coeff_o = (mode_i == compress_pkg::COMPRESS_D12) ? coeff_i : (quot & mask);

endmodule

`default_nettype wire

// ==== logic/compress_sample_buffer.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_sample_buffer (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire [compress_pkg::LANE_BITS-1:0]   data_i,
    input  wire [3:0]                           chunks_i,
    input  wire                                 data_valid_i,
    output logic                                almost_full_o,
    output logic                                word_valid_o,
    output logic [compress_pkg::API_DATA_W-1:0] word_o,
    output logic                                empty_o
);

    logic [compress_pkg::BUF_W-1:0] store_q;
    logic [compress_pkg::BUF_W-1:0] store_d;
    logic [compress_pkg::BUF_CNT_W-1:0] count_q;
    logic [compress_pkg::BUF_CNT_W-1:0] count_d;
    logic [compress_pkg::BUF_CNT_W-1:0] base_cnt;
    logic [compress_pkg::LANE_BITS-1:0] data_masked;
    logic emit;

    // The lowest word leaves as soon as eight nibbles are held
    assign emit = (count_q >= compress_pkg::BUF_CNT_W'(compress_pkg::WORD_NIBBLES));
    assign word_valid_o = emit;
    assign word_o = store_q[compress_pkg::API_DATA_W-1:0];
    assign almost_full_o = (count_q >= compress_pkg::BUF_CNT_W'(compress_pkg::AF_NIBBLES));
    assign empty_o = (count_q == '0);

    // Bits above the valid nibbles must stay zero for the OR below
    assign data_masked = data_i
                       & ~({compress_pkg::LANE_BITS{1'b1}} << (chunks_i * compress_pkg::CHUNK_W));

    always_comb begin
        store_d = emit ? (store_q >> compress_pkg::API_DATA_W) : store_q;
        base_cnt = emit ? count_q - compress_pkg::BUF_CNT_W'(compress_pkg::WORD_NIBBLES) : count_q;
        count_d = base_cnt;
        if (data_valid_i) begin
            // New nibbles land just above the ones left after the emit
            store_d = store_d
                    | (compress_pkg::BUF_W'(data_masked) << (base_cnt * compress_pkg::CHUNK_W));
            count_d = base_cnt + compress_pkg::BUF_CNT_W'(chunks_i);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            store_q <= '0;
            count_q <= '0;
        end else if (zeroize_i) begin
            store_q <= '0;
            count_q <= '0;
        end else begin
            store_q <= store_d;
            count_q <= count_d;
        end
    end

    // The read controller's back-pressure keeps every push within capacity
    assert property (@(posedge clk) disable iff (!reset_n)
        data_valid_i |-> (32'(base_cnt) + 32'(chunks_i) <= compress_pkg::BUF_NIBBLES));

endmodule

`default_nettype wire

// ==== logic/compress_api_port.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_api_port (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire compress_pkg::compress_cmd_t    cmd_i,
    input  wire                                 word_valid_i,
    input  wire [compress_pkg::API_DATA_W-1:0]  word_i,
    output compress_pkg::api_req_t              api_req_o,
    input  wire [compress_pkg::API_DATA_W-1:0]  api_rd_data_i,
    output logic                                compare_failed_o,
    output logic                                pending_o
);

    logic [compress_pkg::MEM_ADDR_W-1:0] addr_q;
    logic compare_q;
    logic cmp_valid_q;
    logic [compress_pkg::API_DATA_W-1:0] cmp_word_q;
    logic mismatch;

    // Each word becomes a write, or in compare mode a read of the stored word
    assign api_req_o.wr_en = word_valid_i && !compare_q;
    assign api_req_o.rd_en = word_valid_i && compare_q;
    assign api_req_o.addr = addr_q;
    assign api_req_o.wr_data = word_i;

    assign mismatch = cmp_valid_q && (api_rd_data_i != cmp_word_q);
    assign pending_o = cmp_valid_q;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr_q <= '0;
            compare_q <= 1'b0;
            cmp_valid_q <= 1'b0;
            compare_failed_o <= 1'b0;
        end else if (zeroize_i) begin
            addr_q <= '0;
            compare_q <= 1'b0;
            cmp_valid_q <= 1'b0;
            compare_failed_o <= 1'b0;
        end else begin
            cmp_valid_q <= word_valid_i && compare_q;
            if (cmd_i.start) begin
                addr_q <= cmd_i.dest_base;
                compare_q <= cmd_i.compare;
            end else if (word_valid_i) begin
                addr_q <= addr_q + compress_pkg::MEM_ADDR_W'(1);
            end
            // Sticky until the next command starts
            if (cmd_i.start) begin
                compare_failed_o <= 1'b0;
            end else if (mismatch) begin
                compare_failed_o <= 1'b1;
            end
        end
    end

    // Held for the cycle in which the API memory answers
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            cmp_word_q <= '0;
        end else if (word_valid_i) begin
            cmp_word_q <= word_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/compress_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_top (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize_i,
    input  wire compress_pkg::compress_cmd_t    cmd_i,
    output compress_pkg::mem_rd_req_t           mem_rd_req_o,
    input  wire [compress_pkg::COEFF_PER_CLK-1:0][compress_pkg::COEFF_W-1:0] mem_rd_data_i,
    input  wire                                 mem_rd_valid_i,
    output compress_pkg::api_req_t              api_req_o,
    input  wire [compress_pkg::API_DATA_W-1:0]  api_rd_data_i,
    output logic                                compare_failed_o,
    output logic                                busy_o,
    output logic                                done_o
);

    compress_pkg::compress_mode_e mode_q;
    logic [compress_pkg::COEFF_PER_CLK-1:0][compress_pkg::COEFF_W-1:0] lane_out;
    logic [compress_pkg::LANE_BITS-1:0] packed_data;
    logic [3:0] chunks;
    logic push;
    logic reads_done;
    logic buf_almost_full;
    logic buf_empty;
    logic word_valid;
    logic [compress_pkg::API_DATA_W-1:0] word;
    logic cmp_pending;

    // Data still in flight after a zeroize is dropped here
    assign push = mem_rd_valid_i && busy_o;

    assign done_o = busy_o && reads_done && !mem_rd_valid_i && buf_empty && !cmp_pending;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_o <= 1'b0;
            mode_q <= compress_pkg::COMPRESS_D1;
        end else if (zeroize_i) begin
            busy_o <= 1'b0;
            mode_q <= compress_pkg::COMPRESS_D1;
        end else if (cmd_i.start) begin
            busy_o <= 1'b1;
            mode_q <= cmd_i.mode;
        end else if (done_o) begin
            busy_o <= 1'b0;
        end
    end

    compress_read_ctrl u_read_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .cmd_i         (cmd_i),
        .almost_full_i (buf_almost_full),
        .mem_rd_req_o  (mem_rd_req_o),
        .reads_done_o  (reads_done)
    );

    for (genvar i = 0; i < compress_pkg::COEFF_PER_CLK; i++) begin : g_lane
        compress_coeff u_coeff (
            .coeff_i (mem_rd_data_i[i]),
            .mode_i  (mode_q),
            .coeff_o (lane_out[i])
        );
    end

    // Lane 0 goes to the lowest bits, and d bits of four lanes make d nibbles
    always_comb begin
        packed_data = '0;
        chunks = 4'd12;
        case (mode_q)
            compress_pkg::COMPRESS_D1: begin
                chunks = 4'd1;
                for (int i = 0; i < compress_pkg::COEFF_PER_CLK; i++) begin
                    packed_data[i] = lane_out[i][0];
                end
            end
            compress_pkg::COMPRESS_D5: begin
                chunks = 4'd5;
                for (int i = 0; i < compress_pkg::COEFF_PER_CLK; i++) begin
                    packed_data[i*5 +: 5] = lane_out[i][4:0];
                end
            end
            compress_pkg::COMPRESS_D11: begin
                chunks = 4'd11;
                for (int i = 0; i < compress_pkg::COEFF_PER_CLK; i++) begin
                    packed_data[i*11 +: 11] = lane_out[i][10:0];
                end
            end
            default: begin
                packed_data = lane_out;
            end
        endcase
    end

    compress_sample_buffer u_sample_buffer (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize_i     (zeroize_i),
        .data_i        (packed_data),
        .chunks_i      (chunks),
        .data_valid_i  (push),
        .almost_full_o (buf_almost_full),
        .word_valid_o  (word_valid),
        .word_o        (word),
        .empty_o       (buf_empty)
    );

    compress_api_port u_api_port (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize_i        (zeroize_i),
        .cmd_i            (cmd_i),
        .word_valid_i     (word_valid),
        .word_i           (word),
        .api_req_o        (api_req_o),
        .api_rd_data_i    (api_rd_data_i),
        .compare_failed_o (compare_failed_o),
        .pending_o        (cmp_pending)
    );

    // Source reads and API words only occur inside an active command
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        (mem_rd_req_o.rd_en || word_valid) |-> busy_o);

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk_o
);

    // Free-running clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk_o = ~clk_o;
        end
    end

endmodule

`default_nettype wire

// ==== tests/compress_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module compress_tb;

    localparam int NUM_ROWS = 9;
    localparam int DONE_TIMEOUT = 5000;
    localparam int MEM_WORDS = 1 << compress_pkg::MEM_ADDR_W;

    typedef struct {
        string                        name;
        compress_pkg::compress_mode_e mode;
        logic                         compare;
        logic [2:0]                   num_poly;
        int                           src_base;
        int                           dest_base;
        int                           corrupt_addr;
        logic                         exp_fail;
        logic                         exp_stall;
        int                           abort_after;
    } test_row_t;

    wire clk;
    logic reset_n = 1'b0;
    logic zeroize = 1'b0;
    compress_pkg::compress_cmd_t cmd = '0;
    compress_pkg::mem_rd_req_t mem_rd_req;
    logic [compress_pkg::COEFF_PER_CLK-1:0][compress_pkg::COEFF_W-1:0] mem_rd_data = '0;
    logic mem_rd_valid = 1'b0;
    compress_pkg::api_req_t api_req;
    logic [compress_pkg::API_DATA_W-1:0] api_rd_data = '0;
    logic compare_failed;
    logic busy;
    logic done;

    logic [compress_pkg::LANE_BITS-1:0] src_mem [MEM_WORDS];
    logic [compress_pkg::API_DATA_W-1:0] api_mem [MEM_WORDS];
    logic corrupt_en = 1'b0;
    logic [compress_pkg::MEM_ADDR_W-1:0] corrupt_addr = '0;

    // Request logs filled by the memory models and only read by the main process
    int cycle_cnt = 0;
    int src_rd_cycle[$];
    int wr_addr_log[$];
    logic [31:0] wr_data_log[$];
    int rd_addr_log[$];

    logic [31:0] exp_words[$];
    test_row_t rows [NUM_ROWS];
    int errors = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk)
    );

    compress_top u_compress_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize_i        (zeroize),
        .cmd_i            (cmd),
        .mem_rd_req_o     (mem_rd_req),
        .mem_rd_data_i    (mem_rd_data),
        .mem_rd_valid_i   (mem_rd_valid),
        .api_req_o        (api_req),
        .api_rd_data_i    (api_rd_data),
        .compare_failed_o (compare_failed),
        .busy_o           (busy),
        .done_o           (done)
    );

    // Source and API memories, both answering reads one cycle later
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        mem_rd_valid <= mem_rd_req.rd_en;
        if (mem_rd_req.rd_en) begin
            mem_rd_data <= src_mem[mem_rd_req.addr];
            src_rd_cycle.push_back(cycle_cnt);
        end
        if (api_req.wr_en) begin
            api_mem[api_req.addr] <= api_req.wr_data;
            wr_addr_log.push_back(int'(api_req.addr));
            wr_data_log.push_back(api_req.wr_data);
        end
        if (api_req.rd_en) begin
            api_rd_data <= api_mem[api_req.addr];
            rd_addr_log.push_back(int'(api_req.addr));
        end
        if (corrupt_en) begin
            api_mem[corrupt_addr] <= api_mem[corrupt_addr] ^ 32'h0000_0100;
        end
    end

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("** Error: %s %s expected %0h actual %0h", test, what, exp, act);
            errors++;
        end
    endtask

    function automatic int mode_bits(input compress_pkg::compress_mode_e mode);
        case (mode)
            compress_pkg::COMPRESS_D1:  return 1;
            compress_pkg::COMPRESS_D5:  return 5;
            compress_pkg::COMPRESS_D11: return 11;
            default:                    return 12;
        endcase
    endfunction

    // round(2^d x / q) mod 2^d, with the rounding done as floor((2^(d+1) x + q) / 2q)
    function automatic logic [11:0] round_compress(input logic [11:0] x, input int d);
        longint unsigned num;
        if (d == 12) begin
            return x;
        end
        num = (longint'(x) << (d + 1)) + 64'(compress_pkg::MLKEM_Q);
        return 12'((num / 64'(2 * compress_pkg::MLKEM_Q)) % (64'd1 << d));
    endfunction

    // Coefficients in address order, lane 0 first, packed least significant bit first
    task automatic build_expected(input int i);
        logic [63:0] acc;
        logic [11:0] x;
        int nbits;
        int d;
        int addr;
        exp_words.delete();
        acc = '0;
        nbits = 0;
        d = mode_bits(rows[i].mode);
        for (int p = 0; p < int'(rows[i].num_poly); p++) begin
            for (int k = 0; k < 256; k++) begin
                addr = rows[i].src_base + p * compress_pkg::READS_PER_POLY + k / 4;
                x = src_mem[addr][(k % 4) * 12 +: 12];
                acc = acc | (64'(round_compress(x, d)) << nbits);
                nbits += d;
                if (nbits >= 32) begin
                    exp_words.push_back(acc[31:0]);
                    acc = acc >> 32;
                    nbits -= 32;
                end
            end
        end
    endtask

    task automatic run_row(input int i);
        int src_mark;
        int wr_mark;
        int rd_mark;
        int n_src;
        int gaps;
        int cycles;
        logic done_seen;
        string name;
        name = rows[i].name;
        build_expected(i);
        if (rows[i].corrupt_addr >= 0) begin
            @(posedge clk);
            corrupt_addr <= compress_pkg::MEM_ADDR_W'(rows[i].corrupt_addr);
            corrupt_en <= 1'b1;
            @(posedge clk);
            corrupt_en <= 1'b0;
        end
        src_mark = src_rd_cycle.size();
        wr_mark = wr_addr_log.size();
        rd_mark = rd_addr_log.size();
        @(posedge clk);
        cmd <= '{start: 1'b1, mode: rows[i].mode, compare: rows[i].compare,
                 num_poly: rows[i].num_poly,
                 src_base: compress_pkg::MEM_ADDR_W'(rows[i].src_base),
                 dest_base: compress_pkg::MEM_ADDR_W'(rows[i].dest_base)};
        @(posedge clk);
        cmd.start <= 1'b0;
        @(negedge clk);
        check_value(name, "failure flag after start", 32'd0, 32'(compare_failed));

        if (rows[i].abort_after > 0) begin
            repeat (rows[i].abort_after) @(negedge clk);
            check_value(name, "failure flag before zeroize", 32'(rows[i].exp_fail),
                        32'(compare_failed));
            @(posedge clk);
            zeroize <= 1'b1;
            @(posedge clk);
            zeroize <= 1'b0;
            @(negedge clk);
            check_value(name, "busy after zeroize", 32'd0, 32'(busy));
            check_value(name, "done after zeroize", 32'd0, 32'(done));
            check_value(name, "source rd_en after zeroize", 32'd0, 32'(mem_rd_req.rd_en));
            check_value(name, "api wr_en after zeroize", 32'd0, 32'(api_req.wr_en));
            check_value(name, "api rd_en after zeroize", 32'd0, 32'(api_req.rd_en));
            check_value(name, "failure flag after zeroize", 32'd0, 32'(compare_failed));
            return;
        end

        done_seen = 1'b0;
        for (cycles = 0; cycles < DONE_TIMEOUT && !done_seen; cycles++) begin
            @(negedge clk);
            done_seen = done;
        end
        assert (done_seen) else begin
            $display("Error: %s never raised done within %0d cycles", name, DONE_TIMEOUT);
            errors++;
        end
        if (!done_seen) begin
            return;
        end
        check_value(name, "failure flag", 32'(rows[i].exp_fail), 32'(compare_failed));

        n_src = src_rd_cycle.size() - src_mark;
        check_value(name, "source reads", 32'(64 * int'(rows[i].num_poly)), 32'(n_src));
        if (rows[i].exp_stall && n_src > 0) begin
            gaps = src_rd_cycle[src_rd_cycle.size() - 1] - src_rd_cycle[src_mark] + 1 - n_src;
            assert (gaps > 0) else begin
                $display("Error: %s issued its reads without any back-pressure stall", name);
                errors++;
            end
        end

        if (rows[i].compare) begin
            check_value(name, "write count", 32'd0, 32'(wr_addr_log.size() - wr_mark));
            check_value(name, "read count", 32'(exp_words.size()),
                        32'(rd_addr_log.size() - rd_mark));
            for (int j = 0; j < exp_words.size() && rd_mark + j < rd_addr_log.size(); j++) begin
                check_value(name, "read address", 32'(rows[i].dest_base + j),
                            32'(rd_addr_log[rd_mark + j]));
            end
        end else begin
            check_value(name, "write count", 32'(exp_words.size()),
                        32'(wr_addr_log.size() - wr_mark));
            for (int j = 0; j < exp_words.size() && wr_mark + j < wr_addr_log.size(); j++) begin
                check_value(name, "write address", 32'(rows[i].dest_base + j),
                            32'(wr_addr_log[wr_mark + j]));
                check_value(name, "write data", exp_words[j], wr_data_log[wr_mark + j]);
            end
        end

        @(negedge clk);
        check_value(name, "busy after done", 32'd0, 32'(busy));
    endtask

    initial begin
        void'($urandom(32'h6e8f_6e1b));
        for (int a = 0; a < MEM_WORDS; a++) begin
            for (int l = 0; l < compress_pkg::COEFF_PER_CLK; l++) begin
                src_mem[a][l * 12 +: 12] = 12'($urandom % compress_pkg::MLKEM_Q);
            end
        end

        // Compare rows 4 to 7 read back the words that rows 0, 1 and 3 wrote
        // Row 5 flips the word at 137, and row 7 meets that word before its zeroize
        rows[0] = '{"d1_write", compress_pkg::COMPRESS_D1, 1'b0, 3'd1, 0, 0, -1, 0, 0, 0};
        rows[1] = '{"d5_write", compress_pkg::COMPRESS_D5, 1'b0, 3'd2, 64, 100, -1, 0, 0, 0};
        rows[2] = '{"d12_write", compress_pkg::COMPRESS_D12, 1'b0, 3'd4, 128, 200, -1, 0, 1, 0};
        rows[3] = '{"d11_write", compress_pkg::COMPRESS_D11, 1'b0, 3'd1, 384, 600, -1, 0, 1, 0};
        rows[4] = '{"d11_compare", compress_pkg::COMPRESS_D11, 1'b1, 3'd1, 384, 600, -1, 0, 1, 0};
        rows[5] = '{"d5_corrupt", compress_pkg::COMPRESS_D5, 1'b1, 3'd2, 64, 100, 137, 1, 0, 0};
        rows[6] = '{"d1_compare", compress_pkg::COMPRESS_D1, 1'b1, 3'd1, 0, 0, -1, 0, 0, 0};
        rows[7] = '{"d5_abort", compress_pkg::COMPRESS_D5, 1'b1, 3'd2, 64, 100, -1, 1, 0, 100};
        rows[8] = '{"d1_fresh", compress_pkg::COMPRESS_D1, 1'b0, 3'd1, 0, 900, -1, 0, 0, 0};

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_value("reset", "source rd_en", 32'd0, 32'(mem_rd_req.rd_en));
        check_value("reset", "api wr_en", 32'd0, 32'(api_req.wr_en));
        check_value("reset", "api rd_en", 32'd0, 32'(api_req.rd_en));
        check_value("reset", "busy", 32'd0, 32'(busy));
        check_value("reset", "done", 32'd0, 32'(done));
        check_value("reset", "failure flag", 32'd0, 32'(compare_failed));
        @(posedge clk);
        reset_n <= 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end

        $display("Simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
logic/compress_pkg.sv
logic/compress_read_ctrl.sv
logic/compress_coeff.sv
logic/compress_sample_buffer.sv
logic/compress_api_port.sv
logic/compress_top.sv
tests/tb_clock_gen.sv
tests/compress_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the compression testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module compress_tb \
    -o compress_sim \
    && ./obj_dir/compress_sim > sim.log 2>&1 \
    || echo "TEST FAILED" >> sim.log

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
